//--- common/rv_macros.svh
// ==============================
// Core-wide sizes, reset PC and
// the RV32I opcode values.
// ==============================

`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// ==============================
// Sizes
// ==============================
`define XLEN        32          // Data and address width.
`define REG_ADDR_W  5           // Register index width.
`define REG_COUNT   32          // Number of integer registers.
`define IMEM_WORDS  64          // Instruction memory depth.
`define DMEM_WORDS  32          // Data memory depth.

`define RESET_PC    32'h0000_0000

// ==============================
// Major opcodes
// ==============================
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011

`endif

//--- common/rv_pkg.sv
// ==============================
// Instruction views, operation
// enums and the stage packets.
// ==============================

`include "rv_macros.svh"

package rv_pkg;

	// ==============================
	// Instruction word views
	// ==============================
	typedef struct packed {
		logic [6:0]               funct7;
		logic [`REG_ADDR_W-1:0]   rs2;
		logic [`REG_ADDR_W-1:0]   rs1;
		logic [2:0]               funct3;
		logic [`REG_ADDR_W-1:0]   rd;
		logic [6:0]               opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0]              imm;
		logic [`REG_ADDR_W-1:0]   rs1;
		logic [2:0]               funct3;
		logic [`REG_ADDR_W-1:0]   rd;
		logic [6:0]               opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0]               imm_hi;
		logic [`REG_ADDR_W-1:0]   rs2;
		logic [`REG_ADDR_W-1:0]   rs1;
		logic [2:0]               funct3;
		logic [4:0]               imm_lo;
		logic [6:0]               opcode;
	} s_fmt_t;   // Also carries the B immediate bits.

	typedef struct packed {
		logic [19:0]              imm;
		logic [`REG_ADDR_W-1:0]   rd;
		logic [6:0]               opcode;
	} u_fmt_t;   // Also carries the J immediate bits.

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		u_fmt_t u_fmt;
	} instr_u;

	// ==============================
	// Operation kinds
	// ==============================
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} alu_op_t;

	typedef enum logic [3:0] {
		JMP_NONE, JMP_BEQ, JMP_BNE, JMP_BLT, JMP_BGE,
		JMP_BLTU, JMP_BGEU, JMP_JAL, JMP_JALR
	} jmp_kind_t;

	typedef enum logic [1:0] {
		MEM_NONE, MEM_LW, MEM_SW
	} mem_op_t;

	// ==============================
	// Stage packets
	// ==============================
	typedef struct packed {
		logic                     valid;
		logic [`XLEN-1:0]         pc;
		instr_u                   instr;
	} fetch_pkt_t;

	typedef struct packed {
		logic                     valid;
		logic [`XLEN-1:0]         pc;
		alu_op_t                  alu_op;
		logic [`XLEN-1:0]         alu_a;
		logic [`XLEN-1:0]         alu_b;
		jmp_kind_t                jmp_kind;
		logic [`XLEN-1:0]         jmp_a;
		logic [`XLEN-1:0]         jmp_b;
		logic [`XLEN-1:0]         rs1_data;
		logic [`XLEN-1:0]         rs2_data;
		mem_op_t                  mem_op;
		logic [`REG_ADDR_W-1:0]   rd;
		logic                     wr_en;
	} exec_pkt_t;

	typedef struct packed {
		logic                     valid;
		logic [`XLEN-1:0]         pc;
		logic                     wr_en;
		logic [`REG_ADDR_W-1:0]   rd;
		logic [`XLEN-1:0]         data;
	} retire_t;

endpackage

//--- hdl/rv_fetch.sv
// ==============================
// Fetch stage: PC register and
// instruction memory.
// ==============================

`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_fetch import rv_pkg::*; (
	input  logic                                clk,
	input  logic                                arst_n,
	input  logic                                run,
	input  logic                                redirect,
	input  logic [`XLEN-1:0]                    redirect_pc,
	input  logic                                imem_wr_en,
	input  logic [$clog2(`IMEM_WORDS)-1:0]      imem_wr_addr,
	input  logic [`XLEN-1:0]                    imem_wr_data,
	output fetch_pkt_t                          fetch
);

	localparam int IMEM_AW = $clog2(`IMEM_WORDS);

	logic [`XLEN-1:0] imem [`IMEM_WORDS];
	logic [`XLEN-1:0] pc_q;
	logic [IMEM_AW-1:0] rd_idx;

	assign rd_idx = pc_q[IMEM_AW+1:2];   // Word index of the PC.

	// ==============================
	// Program counter
	// ==============================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc_q <= `RESET_PC;
		end else if (redirect) begin
			pc_q <= redirect_pc;          // Taken branch or jump.
		end else if (run) begin
			pc_q <= pc_q + `XLEN'd4;
		end
	end

	// Program load is only taken while the core is halted.
	always_ff @(posedge clk) begin
		if (imem_wr_en && !run) begin
			imem[imem_wr_addr] <= imem_wr_data;
		end
	end

	assign fetch.valid = run;
	assign fetch.pc    = pc_q;
	assign fetch.instr = imem[rd_idx];

endmodule

//--- decode/rv_decode.sv
// ==============================
// Decode stage: field split,
// immediates and operand select.
// ==============================

`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_decode import rv_pkg::*; (
	input  fetch_pkt_t                fetch,
	output logic [`REG_ADDR_W-1:0]    rs1_addr,
	output logic [`REG_ADDR_W-1:0]    rs2_addr,
	input  logic [`XLEN-1:0]          rs1_data,
	input  logic [`XLEN-1:0]          rs2_data,
	output exec_pkt_t                 exec
);

	logic [6:0]               opcode;
	logic [2:0]               funct3;
	logic                     alt;
	logic [`REG_ADDR_W-1:0]   rd_f;
	logic [`XLEN-1:0]         imm_i;
	logic [`XLEN-1:0]         imm_s;
	logic [`XLEN-1:0]         imm_b;
	logic [`XLEN-1:0]         imm_u;
	logic [`XLEN-1:0]         imm_j;

	function automatic alu_op_t alu_from_f3(input logic [2:0] f3, input logic sel_alt);
		alu_op_t op;
		case (f3)
			3'b000:  op = sel_alt ? ALU_SUB : ALU_ADD;
			3'b001:  op = ALU_SLL;
			3'b010:  op = ALU_SLT;
			3'b011:  op = ALU_SLTU;
			3'b100:  op = ALU_XOR;
			3'b101:  op = sel_alt ? ALU_SRA : ALU_SRL;
			3'b110:  op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	assign opcode = fetch.instr.r_fmt.opcode;
	assign funct3 = fetch.instr.r_fmt.funct3;
	assign alt    = fetch.instr.r_fmt.funct7[5];   // Instruction bit 30.
	assign rd_f   = fetch.instr.r_fmt.rd;

	assign rs1_addr = fetch.instr.r_fmt.rs1;
	assign rs2_addr = fetch.instr.r_fmt.rs2;

	// ==============================
	// Immediates
	// ==============================
	assign imm_i = {{20{fetch.instr.i_fmt.imm[11]}}, fetch.instr.i_fmt.imm};
	assign imm_s = {{20{fetch.instr.s_fmt.imm_hi[6]}}, fetch.instr.s_fmt.imm_hi,
		fetch.instr.s_fmt.imm_lo};
	assign imm_b = {{20{fetch.instr.s_fmt.imm_hi[6]}}, fetch.instr.s_fmt.imm_lo[0],
		fetch.instr.s_fmt.imm_hi[5:0], fetch.instr.s_fmt.imm_lo[4:1], 1'b0};
	assign imm_u = {fetch.instr.u_fmt.imm, 12'h000};
	assign imm_j = {{12{fetch.instr.u_fmt.imm[19]}}, fetch.instr.u_fmt.imm[7:0],
		fetch.instr.u_fmt.imm[8], fetch.instr.u_fmt.imm[18:9], 1'b0};

	// ==============================
	// Operand and control select
	// ==============================
	always_comb begin
		exec          = '0;               // Bubble unless decoded below.
		exec.valid    = fetch.valid;
		exec.pc       = fetch.pc;
		exec.alu_op   = ALU_ADD;
		exec.jmp_kind = JMP_NONE;
		exec.mem_op   = MEM_NONE;
		exec.rs1_data = rs1_data;
		exec.rs2_data = rs2_data;

		case (opcode)
			`OPC_OP: begin
				exec.alu_op = alu_from_f3(funct3, alt);
				exec.alu_a  = rs1_data;
				exec.alu_b  = rs2_data;
				exec.rd     = rd_f;
				exec.wr_en  = (rd_f != '0);
			end
			`OPC_OP_IMM: begin
				exec.alu_op = alu_from_f3(funct3, alt && (funct3 == 3'b101));
				exec.alu_a  = rs1_data;
				exec.alu_b  = imm_i;
				exec.rd     = rd_f;
				exec.wr_en  = (rd_f != '0);
			end
			`OPC_LUI: begin
				exec.alu_a  = imm_u;
				exec.rd     = rd_f;
				exec.wr_en  = (rd_f != '0);
			end
			`OPC_AUIPC: begin
				exec.alu_a  = fetch.pc;
				exec.alu_b  = imm_u;
				exec.rd     = rd_f;
				exec.wr_en  = (rd_f != '0);
			end
			`OPC_JAL: begin
				exec.alu_a    = fetch.pc;       // Link value.
				exec.alu_b    = `XLEN'd4;
				exec.jmp_kind = JMP_JAL;
				exec.jmp_a    = fetch.pc;
				exec.jmp_b    = imm_j;
				exec.rd       = rd_f;
				exec.wr_en    = (rd_f != '0);
			end
			`OPC_JALR: begin
				if (funct3 == 3'b000) begin
					exec.alu_a    = fetch.pc;
					exec.alu_b    = `XLEN'd4;
					exec.jmp_kind = JMP_JALR;
					exec.jmp_a    = rs1_data;
					exec.jmp_b    = imm_i;
					exec.rd       = rd_f;
					exec.wr_en    = (rd_f != '0);
				end
			end
			`OPC_BRANCH: begin
				exec.jmp_a = fetch.pc;
				exec.jmp_b = imm_b;
				case (funct3)
					3'b000:  exec.jmp_kind = JMP_BEQ;
					3'b001:  exec.jmp_kind = JMP_BNE;
					3'b100:  exec.jmp_kind = JMP_BLT;
					3'b101:  exec.jmp_kind = JMP_BGE;
					3'b110:  exec.jmp_kind = JMP_BLTU;
					3'b111:  exec.jmp_kind = JMP_BGEU;
					default: exec.jmp_kind = JMP_NONE;
				endcase
			end
			`OPC_LOAD: begin
				if (funct3 == 3'b010) begin
					exec.alu_a  = rs1_data;
					exec.alu_b  = imm_i;
					exec.mem_op = MEM_LW;
					exec.rd     = rd_f;
					exec.wr_en  = (rd_f != '0);
				end
			end
			`OPC_STORE: begin
				if (funct3 == 3'b010) begin
					exec.alu_a  = rs1_data;
					exec.alu_b  = imm_s;
					exec.mem_op = MEM_SW;
				end
			end
			default: begin
				exec.wr_en = 1'b0;             // Unsupported opcode.
			end
		endcase
	end

endmodule

//--- hdl/rv_regfile.sv
// ==============================
// Integer register file with
// write-through bypass.
// ==============================

`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_regfile (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic [`REG_ADDR_W-1:0]    rs1_addr,
	input  logic [`REG_ADDR_W-1:0]    rs2_addr,
	output logic [`XLEN-1:0]          rs1_data,
	output logic [`XLEN-1:0]          rs2_data,
	input  logic                      wr_en,
	input  logic [`REG_ADDR_W-1:0]    wr_addr,
	input  logic [`XLEN-1:0]          wr_data
);

	logic [`XLEN-1:0] regs [`REG_COUNT];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Same-cycle writes reach the reader directly.
	assign rs1_data = (rs1_addr == '0) ? '0 :
		(wr_en && (wr_addr == rs1_addr)) ? wr_data : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 :
		(wr_en && (wr_addr == rs2_addr)) ? wr_data : regs[rs2_addr];

endmodule

//--- execute/rv_execute.sv
// ==============================
// Execute stage: ALU, branch
// resolve, data memory, retire.
// ==============================

`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_execute import rv_pkg::*; (
	input  logic                      clk,
	input  logic                      arst_n,
	input  exec_pkt_t                 exec,
	output logic                      wr_en,
	output logic [`REG_ADDR_W-1:0]    wr_addr,
	output logic [`XLEN-1:0]          wr_data,
	output logic                      redirect,
	output logic [`XLEN-1:0]          redirect_pc,
	output retire_t                   retire
);

	localparam int DMEM_AW = $clog2(`DMEM_WORDS);

	logic [`XLEN-1:0]   dmem [`DMEM_WORDS];
	logic [`XLEN-1:0]   alu_res;
	logic [`XLEN-1:0]   jmp_sum;
	logic [`XLEN-1:0]   load_data;
	logic [DMEM_AW-1:0] mem_idx;
	logic               eq;
	logic               lt;
	logic               ltu;
	logic               taken;

	// ==============================
	// ALU
	// ==============================
	always_comb begin
		case (exec.alu_op)
			ALU_SUB:  alu_res = exec.alu_a - exec.alu_b;
			ALU_SLL:  alu_res = exec.alu_a << exec.alu_b[4:0];
			ALU_SLT:  alu_res = {{(`XLEN-1){1'b0}}, $signed(exec.alu_a) < $signed(exec.alu_b)};
			ALU_SLTU: alu_res = {{(`XLEN-1){1'b0}}, exec.alu_a < exec.alu_b};
			ALU_XOR:  alu_res = exec.alu_a ^ exec.alu_b;
			ALU_SRL:  alu_res = exec.alu_a >> exec.alu_b[4:0];
			ALU_SRA:  alu_res = $signed(exec.alu_a) >>> exec.alu_b[4:0];
			ALU_OR:   alu_res = exec.alu_a | exec.alu_b;
			ALU_AND:  alu_res = exec.alu_a & exec.alu_b;
			default:  alu_res = exec.alu_a + exec.alu_b;
		endcase
	end

	// ==============================
	// Branch and jump resolve
	// ==============================
	assign eq  = (exec.rs1_data == exec.rs2_data);
	assign lt  = ($signed(exec.rs1_data) < $signed(exec.rs2_data));
	assign ltu = (exec.rs1_data < exec.rs2_data);

	always_comb begin
		case (exec.jmp_kind)
			JMP_BEQ:  taken = eq;
			JMP_BNE:  taken = !eq;
			JMP_BLT:  taken = lt;
			JMP_BGE:  taken = !lt;
			JMP_BLTU: taken = ltu;
			JMP_BGEU: taken = !ltu;
			JMP_JAL,
			JMP_JALR: taken = 1'b1;
			default:  taken = 1'b0;
		endcase
	end

	assign jmp_sum     = exec.jmp_a + exec.jmp_b;
	assign redirect    = exec.valid && taken;
	assign redirect_pc = (exec.jmp_kind == JMP_JALR) ? {jmp_sum[`XLEN-1:1], 1'b0} : jmp_sum;

	// ==============================
	// Data memory
	// ==============================
	assign mem_idx   = alu_res[DMEM_AW+1:2];   // Word address.
	assign load_data = dmem[mem_idx];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `DMEM_WORDS; i++) begin
				dmem[i] <= '0;
			end
		end else if (exec.valid && (exec.mem_op == MEM_SW)) begin
			dmem[mem_idx] <= exec.rs2_data;
		end
	end

	// Write-back and retire report.
	assign wr_en   = exec.valid && exec.wr_en;
	assign wr_addr = exec.rd;
	assign wr_data = (exec.mem_op == MEM_LW) ? load_data : alu_res;

	assign retire.valid = exec.valid;
	assign retire.pc    = exec.pc;
	assign retire.wr_en = wr_en;
	assign retire.rd    = exec.rd;
	assign retire.data  = wr_en ? wr_data : '0;   // Zero when nothing is written.

endmodule

//--- hdl/rv_core.sv
// ==============================
// Three-stage RV32I core top with
// pipeline registers and flush.
// ==============================

`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_core import rv_pkg::*; (
	input  logic                                clk,
	input  logic                                arst_n,
	input  logic                                run,
	input  logic                                imem_wr_en,
	input  logic [$clog2(`IMEM_WORDS)-1:0]      imem_wr_addr,
	input  logic [`XLEN-1:0]                    imem_wr_data,
	output retire_t                             retire
);

	fetch_pkt_t               fetch_pkt;
	fetch_pkt_t               fd_q;
	exec_pkt_t                exec_d;
	exec_pkt_t                de_q;
	logic [`REG_ADDR_W-1:0]   rs1_addr;
	logic [`REG_ADDR_W-1:0]   rs2_addr;
	logic [`XLEN-1:0]         rs1_data;
	logic [`XLEN-1:0]         rs2_data;
	logic                     wr_en;
	logic [`REG_ADDR_W-1:0]   wr_addr;
	logic [`XLEN-1:0]         wr_data;
	logic                     redirect;
	logic [`XLEN-1:0]         redirect_pc;

	rv_fetch u_fetch (
		.clk          (clk),
		.arst_n       (arst_n),
		.run          (run),
		.redirect     (redirect),
		.redirect_pc  (redirect_pc),
		.imem_wr_en   (imem_wr_en),
		.imem_wr_addr (imem_wr_addr),
		.imem_wr_data (imem_wr_data),
		.fetch        (fetch_pkt)
	);

	rv_decode u_decode (
		.fetch    (fd_q),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.exec     (exec_d)
	);

	rv_regfile u_regfile (
		.clk      (clk),
		.arst_n   (arst_n),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data)
	);

	rv_execute u_execute (
		.clk         (clk),
		.arst_n      (arst_n),
		.exec        (de_q),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.retire      (retire)
	);

	// ==============================
	// Pipeline registers
	// ==============================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fd_q <= '0;
			de_q <= '0;
		end else begin
			fd_q <= fetch_pkt;
			de_q <= exec_d;
			if (redirect) begin
				fd_q.valid <= 1'b0;   // Squash the two younger slots.
				de_q.valid <= 1'b0;
			end
		end
	end

endmodule

//--- tests/rv_core_sva.sv
// ==============================
// Bound checks on the core's
// pipeline and retire port.
// ==============================

`timescale 1ns/1ps

module rv_core_sva import rv_pkg::*; (
	input logic         clk,
	input logic         arst_n,
	input logic         redirect,
	input fetch_pkt_t   fetch_pkt,
	input retire_t      retire
);

	int fail_count = 0;

	reset_quiet: assert property (@(posedge clk) !arst_n |-> !retire.valid)
		else begin
			fail_count++;
			$error("retire.valid high while reset is applied");
		end

	write_has_rd: assert property (@(posedge clk) disable iff (!arst_n)
		retire.wr_en |-> (retire.rd != '0))
		else begin
			fail_count++;
			$error("retire.wr_en high with rd equal to x0");
		end

	// Both younger slots are squashed.
	flush_gap: assert property (@(posedge clk) disable iff (!arst_n)
		redirect |=> !retire.valid ##1 !retire.valid)
		else begin
			fail_count++;
			$error("instruction retired inside the two cycles after a redirect");
		end

	pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
		fetch_pkt.pc[1:0] == 2'b00)
		else begin
			fail_count++;
			$error("fetch PC is not word aligned");
		end

endmodule

bind rv_core rv_core_sva u_sva (
	.clk       (clk),
	.arst_n    (arst_n),
	.redirect  (redirect),
	.fetch_pkt (fetch_pkt),
	.retire    (retire)
);

//--- tests/tb_rv_core.sv
// ==============================
// Testbench for the RV32I core.
// Loads a program, checks retires.
// ==============================

`timescale 1ns/1ps

`include "rv_macros.svh"

module tb_rv_core import rv_pkg::*; ();

	localparam int IMEM_AW        = $clog2(`IMEM_WORDS);
	localparam int RETIRE_TIMEOUT = 50;

	// One expected retire record; test 0 marks a squashed slot.
	typedef struct packed {
		logic [2:0]               test;
		logic [`XLEN-1:0]         pc;
		logic                     wr_en;
		logic [`REG_ADDR_W-1:0]   rd;
		logic [`XLEN-1:0]         data;
	} expect_t;

	logic                 clk;
	logic                 arst_n;
	logic                 run;
	logic                 imem_wr_en;
	logic [IMEM_AW-1:0]   imem_wr_addr;
	logic [`XLEN-1:0]     imem_wr_data;
	retire_t              retire;

	logic [`XLEN-1:0]     prog [$];
	expect_t              exp_q [$];
	int                   errors;
	int                   tests_passed;
	int                   tests_failed;
	int                   test_errors [7] = '{default: 0};
	bit                   timed_out;
	string                test_names [7] = '{"none", "ALU chain", "upper immediates",
		"memory", "branches", "jumps", "illegal and x0"};

	rv_core DUT (
		.clk          (clk),
		.arst_n       (arst_n),
		.run          (run),
		.imem_wr_en   (imem_wr_en),
		.imem_wr_addr (imem_wr_addr),
		.imem_wr_data (imem_wr_data),
		.retire       (retire)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	// ==============================
	// Instruction encoders
	// ==============================
	function automatic logic [31:0] r_type(input logic [6:0] f7, input int rs2, input int rs1,
		input logic [2:0] f3, input int rd);
		instr_u w;
		w.r_fmt = {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), `OPC_OP};
		return w;
	endfunction

	function automatic logic [31:0] i_type(input int imm, input int rs1, input logic [2:0] f3,
		input int rd, input logic [6:0] opc);
		instr_u w;
		w.i_fmt = {12'(imm), 5'(rs1), f3, 5'(rd), opc};
		return w;
	endfunction

	function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
		instr_u      w;
		logic [11:0] s;
		s = 12'(imm);
		w.s_fmt = {s[11:5], 5'(rs2), 5'(rs1), 3'b010, s[4:0], `OPC_STORE};
		return w;
	endfunction

	function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
		input logic [2:0] f3);
		instr_u      w;
		logic [12:0] b;
		b = 13'(imm);
		w.s_fmt = {b[12], b[10:5], 5'(rs2), 5'(rs1), f3, b[4:1], b[11], `OPC_BRANCH};
		return w;
	endfunction

	function automatic logic [31:0] u_type(input int imm, input int rd, input logic [6:0] opc);
		instr_u w;
		w.u_fmt = {20'(imm), 5'(rd), opc};
		return w;
	endfunction

	function automatic logic [31:0] j_type(input int imm, input int rd);
		instr_u      w;
		logic [20:0] j;
		j = 21'(imm);
		w.u_fmt = {j[20], j[10:1], j[11], j[19:12], 5'(rd), `OPC_JAL};
		return w;
	endfunction

	task automatic add_instr(input logic [31:0] word, input int test, input logic wr_en,
		input int rd, input logic [31:0] data);
		expect_t e;
		e.test  = 3'(test);
		e.pc    = `XLEN'(prog.size() * 4);
		e.wr_en = wr_en;
		e.rd    = 5'(rd);
		e.data  = data;
		prog.push_back(word);
		if (test != 0) begin
			exp_q.push_back(e);
		end
	endtask

	// ==============================
	// Program and expected retires
	// ==============================
	task automatic build_program();
		add_instr(i_type(5, 0, 3'b000, 1, `OPC_OP_IMM), 1, 1'b1, 1, 32'h0000_0005);
		add_instr(i_type(-12, 1, 3'b000, 2, `OPC_OP_IMM), 1, 1'b1, 2, 32'hFFFF_FFF9);
		add_instr(r_type(7'h00, 1, 2, 3'b000, 3), 1, 1'b1, 3, 32'hFFFF_FFFE);   // ADD.
		add_instr(r_type(7'h20, 1, 3, 3'b000, 4), 1, 1'b1, 4, 32'hFFFF_FFF9);   // SUB.
		add_instr(r_type(7'h00, 1, 4, 3'b010, 5), 1, 1'b1, 5, 32'h0000_0001);   // SLT.
		add_instr(r_type(7'h00, 4, 5, 3'b011, 6), 1, 1'b1, 6, 32'h0000_0001);   // SLTU.
		add_instr(r_type(7'h00, 4, 6, 3'b100, 7), 1, 1'b1, 7, 32'hFFFF_FFF8);   // XOR.
		add_instr(r_type(7'h00, 1, 7, 3'b110, 8), 1, 1'b1, 8, 32'hFFFF_FFFD);   // OR.
		add_instr(r_type(7'h00, 2, 8, 3'b111, 9), 1, 1'b1, 9, 32'hFFFF_FFF9);   // AND.
		add_instr(r_type(7'h00, 1, 9, 3'b001, 10), 1, 1'b1, 10, 32'hFFFF_FF20);  // SLL.
		add_instr(r_type(7'h20, 1, 10, 3'b101, 11), 1, 1'b1, 11, 32'hFFFF_FFF9); // SRA.
		add_instr(r_type(7'h00, 1, 11, 3'b101, 12), 1, 1'b1, 12, 32'h07FF_FFFF); // SRL.
		add_instr(u_type(32'h12345, 13, `OPC_LUI), 2, 1'b1, 13, 32'h1234_5000);
		add_instr(u_type(1, 14, `OPC_AUIPC), 2, 1'b1, 14, 32'h0000_1034);
		add_instr(i_type(8, 0, 3'b000, 15, `OPC_OP_IMM), 3, 1'b1, 15, 32'h0000_0008);
		add_instr(s_type(4, 13, 15), 3, 1'b0, 0, 32'h0);
		add_instr(i_type(4, 15, 3'b010, 16, `OPC_LOAD), 3, 1'b1, 16, 32'h1234_5000);
		add_instr(b_type(12, 16, 13, 3'b000), 4, 1'b0, 0, 32'h0);               // BEQ taken.
		add_instr(i_type(1, 0, 3'b000, 17, `OPC_OP_IMM), 0, 1'b0, 0, 32'h0);
		add_instr(i_type(2, 0, 3'b000, 17, `OPC_OP_IMM), 0, 1'b0, 0, 32'h0);
		add_instr(b_type(12, 1, 2, 3'b100), 4, 1'b0, 0, 32'h0);                 // BLT taken.
		add_instr(i_type(1, 0, 3'b000, 18, `OPC_OP_IMM), 0, 1'b0, 0, 32'h0);
		add_instr(i_type(2, 0, 3'b000, 18, `OPC_OP_IMM), 0, 1'b0, 0, 32'h0);
		add_instr(b_type(8, 1, 1, 3'b001), 4, 1'b0, 0, 32'h0);                  // BNE falls through.
		add_instr(i_type(33, 0, 3'b000, 18, `OPC_OP_IMM), 4, 1'b1, 18, 32'h0000_0021);
		add_instr(j_type(12, 19), 5, 1'b1, 19, 32'h0000_0068);
		add_instr(i_type(1, 0, 3'b000, 20, `OPC_OP_IMM), 0, 1'b0, 0, 32'h0);
		add_instr(i_type(2, 0, 3'b000, 20, `OPC_OP_IMM), 0, 1'b0, 0, 32'h0);
		add_instr(i_type(131, 0, 3'b000, 20, `OPC_OP_IMM), 5, 1'b1, 20, 32'h0000_0083);
		add_instr(i_type(2, 20, 3'b000, 21, `OPC_JALR), 5, 1'b1, 21, 32'h0000_0078);
		add_instr(i_type(1, 0, 3'b000, 23, `OPC_OP_IMM), 0, 1'b0, 0, 32'h0);
		add_instr(i_type(2, 0, 3'b000, 23, `OPC_OP_IMM), 0, 1'b0, 0, 32'h0);
		add_instr(i_type(3, 0, 3'b000, 23, `OPC_OP_IMM), 0, 1'b0, 0, 32'h0);
		add_instr(u_type(0, 5, 7'h7F), 6, 1'b0, 0, 32'h0);                      // Unknown opcode.
		add_instr(i_type(5, 1, 3'b000, 0, `OPC_OP_IMM), 6, 1'b0, 0, 32'h0);
		add_instr(r_type(7'h00, 1, 0, 3'b000, 22), 6, 1'b1, 22, 32'h0000_0005);
		add_instr(j_type(0, 0), 6, 1'b0, 0, 32'h0);                             // Spin here.
	endtask

	task automatic load_program();
		for (int i = 0; i < prog.size(); i++) begin
			@(posedge clk);
			imem_wr_en   <= 1'b1;
			imem_wr_addr <= IMEM_AW'(i);
			imem_wr_data <= prog[i];
		end
	endtask

	task automatic check_retire(input expect_t e);
		int bad;
		bad = 0;
		assert (retire.pc == e.pc) else begin
			$display("MISMATCH time %0t retire.pc expected %h got %h", $time, e.pc, retire.pc);
			bad++;
		end
		assert (retire.wr_en == e.wr_en) else begin
			$display("MISMATCH time %0t retire.wr_en expected %b got %b", $time, e.wr_en,
				retire.wr_en);
			bad++;
		end
		if (e.wr_en) begin
			assert (retire.rd == e.rd) else begin
				$display("MISMATCH time %0t retire.rd expected %0d got %0d", $time, e.rd,
					retire.rd);
				bad++;
			end
			assert (retire.data == e.data) else begin
				$display("MISMATCH time %0t retire.data expected %h got %h", $time, e.data,
					retire.data);
				bad++;
			end
		end
		errors += bad;
		test_errors[e.test] += bad;
	endtask

	task automatic report_test(input int t);
		if (test_errors[t] == 0) begin
			tests_passed++;
			$display("Test %0d (%s): passed", t, test_names[t]);
		end else begin
			tests_failed++;
			$display("Test %0d (%s): failed with %0d errors", t, test_names[t], test_errors[t]);
		end
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		int waited;
		arst_n       = 1'b0;
		run          = 1'b0;
		imem_wr_en   = 1'b0;
		imem_wr_addr = '0;
		imem_wr_data = '0;
		errors       = 0;
		tests_passed = 0;
		tests_failed = 0;
		timed_out    = 1'b0;
		build_program();
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;
		load_program();
		@(posedge clk);
		imem_wr_en <= 1'b0;
		run        <= 1'b1;

		for (int i = 0; i < exp_q.size(); i++) begin
			waited = 0;
			@(negedge clk);
			while (!retire.valid && waited < RETIRE_TIMEOUT) begin
				@(negedge clk);
				waited++;
			end
			if (!retire.valid) begin
				$display("Timeout: nothing retired within %0d cycles while waiting for pc %h",
					RETIRE_TIMEOUT, exp_q[i].pc);
				timed_out = 1'b1;
				test_errors[exp_q[i].test]++;
				report_test(exp_q[i].test);
				break;
			end
			check_retire(exp_q[i]);
			if (i == exp_q.size() - 1) begin
				report_test(exp_q[i].test);
			end else if (exp_q[i + 1].test != exp_q[i].test) begin
				report_test(exp_q[i].test);
			end
		end

		$display("Summary: %0d tests passed, %0d tests failed, %0d mismatches, %0d %s",
			tests_passed, tests_failed, errors, DUT.u_sva.fail_count, "assertion failures");
		if (errors == 0 && !timed_out && DUT.u_sva.fail_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- files.f
+incdir+common
common/rv_pkg.sv
hdl/rv_fetch.sv
decode/rv_decode.sv
hdl/rv_regfile.sv
execute/rv_execute.sv
hdl/rv_core.sv
tests/rv_core_sva.sv
tests/tb_rv_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the core testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert --timing -f files.f --top-module tb_rv_core \
	-o Vtb_rv_core > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see $BUILD_LOG"
	exit 1
fi

./obj_dir/Vtb_rv_core > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -qF "** FAIL **" "$SIM_LOG"; then
	echo "Simulation reported failure"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi
if ! grep -qF "** PASS **" "$SIM_LOG"; then
	echo "Simulation ended without a result"
	exit 1
fi
exit 0
